// File: fmul_golden.txt
// columns: operand a, operand b, expected y, expected ovf (hex)
// normal, subnormal, special and overflow products in that order
3f800000 3f800000 3f800000 0
40000000 40400000 40c00000 0
3fc00000 3fc00000 40100000 0
c0000000 3f000000 bf800000 0
40400000 c0400000 c1100000 0
3f000000 3e800000 3e000000 0
3f800001 3f800001 3f800002 0
3f800001 3fc00000 3fc00002 0
3f800003 3fc00000 3fc00005 0
3fa1e58f 3fca6691 40000000 0
40490fdb 40000000 40c90fdb 0
bf800000 bf800000 3f800000 0
3fffffff 3fffffff 407ffffe 0
00000001 3f800000 00000001 0
00400000 40000000 00800000 0
00800000 3f000000 00400000 0
00800000 3e800000 00200000 0
00ffffff 3f000000 00800000 0
00800001 3f000000 00400001 0
00000001 00000001 00000000 0
00000000 40400000 00000000 0
80000000 40400000 80000000 0
00000001 4b000000 00800000 0
3f800000 7fa00000 7fe00000 0
ffc00001 7f800001 7fc00001 0
ff800005 40000000 ffc00005 0
7f800000 00000000 ffc00000 0
80000000 7f800000 ffc00000 0
7f800000 c0000000 ff800000 0
40400000 ff800000 ff800000 0
7f800000 7f800000 7f800000 0
7f800000 00000001 7f800000 0
00000000 7fc00000 7fc00000 0
7f000000 40000000 7f800000 1
7f7fffff 7f7fffff 7f800000 1
ff000000 40400000 ff800000 1
7f7fffff 3f800000 7f7fffff 0
7f21e58f 3fca6691 7f800000 1
7f7fffff 3f800001 7f800000 1

// File: list.f
fmul_pkg.sv
fmul_unpack.sv
fmul_normalize.sv
fmul_round_pack.sv
fmul_result_buffer.sv
fmul_top.sv
tb_clock_gen.sv
fmul_assertions.sv
fmul_checker.sv
fmul_tb.sv

// File: run.sh
#!/bin/bash
# build the fmul testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fmul_tb -f list.f -o fmul_sim \
   && ./obj_dir/fmul_sim > sim.log 2>&1 \
   ; cat sim.log 2>/dev/null \
   ; grep -q "Simulation PASSED" sim.log \
   && echo "fmul run passed" \
   || { echo "fmul run failed"; exit 1; }

// File: fmul_tb.sv
`timescale 1ns/10ps

module fmul_tb;

   localparam int NUM_VEC     = 39;
   localparam int BUF_DEPTH   = 4;
   localparam int OUT_CREDITS = 2;
   localparam int MAX_CYCLES  = 20 * NUM_VEC + 100;

   logic        clk;
   logic        arst_n;
   logic        in_valid   = 1'b0;
   logic [31:0] in_a       = '0;
   logic [31:0] in_b       = '0;
   logic        out_credit = 1'b0;
   logic        in_credit;
   logic        out_valid;
   logic [31:0] out_y;
   logic        out_ovf;

   // four words per vector for a, b, y and ovf
   logic [31:0] golden [NUM_VEC*4];
   integer      seed = 9;
   int          vec_idx;
   int          in_credits;
   int          dut_credits;
   int          cycles = 0;
   int          received;
   int          value_errs;
   int          flow_errs;

   tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(10)) clock_gen (.clk(clk), .arst_n(arst_n));

   fmul_top #(.BUF_DEPTH(BUF_DEPTH), .OUT_CREDITS(OUT_CREDITS)) uut
      (  .clk        (clk),
         .arst_n     (arst_n),
         .in_valid   (in_valid),
         .in_a       (in_a),
         .in_b       (in_b),
         .in_credit  (in_credit),
         .out_valid  (out_valid),
         .out_y      (out_y),
         .out_ovf    (out_ovf),
         .out_credit (out_credit));

   fmul_checker
      #( .NUM_VEC     (NUM_VEC),
         .BUF_DEPTH   (BUF_DEPTH),
         .OUT_CREDITS (OUT_CREDITS))
   result_check
      (  .clk        (clk),
         .arst_n     (arst_n),
         .golden     (golden),
         .in_valid   (in_valid),
         .in_credit  (in_credit),
         .out_valid  (out_valid),
         .out_y      (out_y),
         .out_ovf    (out_ovf),
         .out_credit (out_credit),
         .received   (received),
         .value_errs (value_errs),
         .flow_errs  (flow_errs));

   initial begin
      $readmemh("fmul_golden.txt", golden);
   end

   // producer spends one credit per operand pair
   always @(posedge clk or negedge arst_n) begin : drive_operands
      logic send;
      if (!arst_n) begin
         in_valid   <= 1'b0;
         vec_idx    <= 0;
         in_credits <= BUF_DEPTH;
      end else begin
         send = (in_credits > 0) && (vec_idx < NUM_VEC);
         in_valid <= send;
         if (send) begin
            in_a    <= golden[vec_idx*4];
            in_b    <= golden[vec_idx*4+1];
            vec_idx <= vec_idx + 1;
         end
         in_credits <= in_credits + int'(in_credit) - int'(send);
      end
   end

   // consumer hands back credits at random gaps below the counter limit
   always @(posedge clk or negedge arst_n) begin : return_credits
      logic give;
      if (!arst_n) begin
         out_credit  <= 1'b0;
         dut_credits <= OUT_CREDITS;
      end else begin
         give = (($random(seed) & 3) == 0) && (dut_credits < 6);
         out_credit  <= give;
         dut_credits <= dut_credits + int'(give) - int'(out_valid);
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles == MAX_CYCLES) begin
         $display("timeout after %0d cycles with %0d of %0d results received",
                  cycles, received, NUM_VEC);
         $display("Simulation FAILED");
         $finish;
      end
   end

   initial begin
      wait (arst_n === 1'b1);
      wait (received == NUM_VEC);
      // a few more cycles to catch stray results
      repeat (10) @(posedge clk);
      $display("checked %0d of %0d results: %0d value errors, %0d flow errors",
               received, NUM_VEC, value_errs, flow_errs);
      if (value_errs == 0 && flow_errs == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// File: fmul_checker.sv
`timescale 1ns/10ps

module fmul_checker
   #( parameter int NUM_VEC     = 1,
      parameter int BUF_DEPTH   = 4,
      parameter int OUT_CREDITS = 2)
   (  input  logic        clk,
      input  logic        arst_n,
      input  logic [31:0] golden [NUM_VEC*4],
      input  logic        in_valid,
      input  logic        in_credit,
      input  logic        out_valid,
      input  logic [31:0] out_y,
      input  logic        out_ovf,
      input  logic        out_credit,
      output int          received,
      output int          value_errs,
      output int          flow_errs);

   int outstanding;
   int popped;
   int returned;

   always @(posedge clk or negedge arst_n) begin : compare_results
      int in_flight;
      int new_flow_errs;
      if (!arst_n) begin
         received    <= 0;
         value_errs  <= 0;
         flow_errs   <= 0;
         outstanding <= 0;
         popped      <= 0;
         returned    <= 0;
      end else begin
         new_flow_errs = 0;
         in_flight     = outstanding + int'(in_valid) - int'(out_valid);
         // operands sent and not yet delivered must fit the buffer
         if (in_flight > BUF_DEPTH) begin
            $display("more operands outstanding than buffer slots at %0t", $time);
            new_flow_errs = new_flow_errs + 1;
         end
         // one upstream credit per delivered result, same cycle
         if (in_credit !== out_valid) begin
            $display("upstream credit pulse out of step with the results at %0t", $time);
            new_flow_errs = new_flow_errs + 1;
         end
         outstanding <= in_flight;
         returned    <= returned + int'(out_credit);
         if (out_valid) begin
            popped <= popped + 1;
            if (popped + 1 > OUT_CREDITS + returned) begin
               $display("result sent without a downstream credit at %0t", $time);
               new_flow_errs = new_flow_errs + 1;
            end
            if (received >= NUM_VEC) begin
               $display("extra result after the last vector at %0t", $time);
               new_flow_errs = new_flow_errs + 1;
            end else begin
               if (out_y !== golden[received*4+2] || out_ovf !== golden[received*4+3][0]) begin
                  $display("ERR %0t: vector %0d a=%h b=%h gave y=%h ovf=%b, expected y=%h ovf=%b",
                           $time, received, golden[received*4], golden[received*4+1],
                           out_y, out_ovf, golden[received*4+2], golden[received*4+3][0]);
                  value_errs <= value_errs + 1;
               end
               received <= received + 1;
            end
         end
         flow_errs <= flow_errs + new_flow_errs;
      end
   end

endmodule

// File: fmul_assertions.sv
`timescale 1ns/10ps

module fmul_assertions
   #( parameter int BUF_DEPTH   = 4,
      parameter int OUT_CREDITS = 2)
   (  input logic                              clk,
      input logic                              arst_n,
      input logic                              out_valid,
      input logic                              out_credit,
      input logic                              wr_en,
      input logic [$clog2(BUF_DEPTH + 1)-1:0]  count);

   localparam int CW = $clog2(BUF_DEPTH + 1);

   // downstream credits as seen from the consumer side
   int held;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         held <= OUT_CREDITS;
      end else begin
         held <= held + int'(out_credit) - int'(out_valid);
      end
   end

   pop_needs_credit: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid |-> (held > 0))
      else $error("buffer popped with no downstream credit");

   no_write_when_full: assert property (@(posedge clk) disable iff (!arst_n)
      wr_en |-> (count != CW'(BUF_DEPTH)))
      else $error("buffer written while full");

   quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !out_valid)
      else $error("out_valid high during reset");

endmodule

bind fmul_result_buffer fmul_assertions
   #( .BUF_DEPTH   (BUF_DEPTH),
      .OUT_CREDITS (OUT_CREDITS))
   buf_checks
   (  .clk        (clk),
      .arst_n     (arst_n),
      .out_valid  (out_valid),
      .out_credit (out_credit),
      .wr_en      (wr_en),
      .count      (count));

// File: tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen
   #( parameter int PERIOD_NS    = 40,
      parameter int RESET_CYCLES = 10)
   (  output logic clk,
      output logic arst_n);

   initial begin
      clk    = 1'b0;
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      arst_n <= 1'b1;
   end

   always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// File: fmul_top.sv
`timescale 1ns/10ps
`default_nettype none

module fmul_top
   import fmul_pkg::*;
   #( parameter int BUF_DEPTH   = 4,
      parameter int OUT_CREDITS = 2)
   (  input  logic   clk,
      input  logic   arst_n,
      input  logic   in_valid,
      input  float_t in_a,
      input  float_t in_b,
      output logic   in_credit,
      output logic   out_valid,
      output float_t out_y,
      output logic   out_ovf,
      input  logic   out_credit);

   // unpack to normalize
   logic   u_valid;
   logic   u_sign;
   mant_t  u_mant_a;
   mant_t  u_mant_b;
   wexp_t  u_exp_sum;
   float_t u_special;
   logic   u_is_special;
   logic   u_ovf_possible;

   // normalize to round
   logic   n_valid;
   logic   n_sign;
   prod_t  n_frac;
   wexp_t  n_exp;
   float_t n_special;
   logic   n_is_special;
   logic   n_ovf_possible;

   // round to buffer
   logic   r_valid;
   float_t r_y;
   logic   r_ovf;

   fmul_unpack u_unpack
      (  .clk            (clk),
         .arst_n         (arst_n),
         .in_valid       (in_valid),
         .in_a           (in_a),
         .in_b           (in_b),
         .u_valid        (u_valid),
         .u_sign         (u_sign),
         .u_mant_a       (u_mant_a),
         .u_mant_b       (u_mant_b),
         .u_exp_sum      (u_exp_sum),
         .u_special      (u_special),
         .u_is_special   (u_is_special),
         .u_ovf_possible (u_ovf_possible));

   fmul_normalize u_normalize
      (  .clk            (clk),
         .arst_n         (arst_n),
         .u_valid        (u_valid),
         .u_sign         (u_sign),
         .u_mant_a       (u_mant_a),
         .u_mant_b       (u_mant_b),
         .u_exp_sum      (u_exp_sum),
         .u_special      (u_special),
         .u_is_special   (u_is_special),
         .u_ovf_possible (u_ovf_possible),
         .n_valid        (n_valid),
         .n_sign         (n_sign),
         .n_frac         (n_frac),
         .n_exp          (n_exp),
         .n_special      (n_special),
         .n_is_special   (n_is_special),
         .n_ovf_possible (n_ovf_possible));

   fmul_round_pack u_round_pack
      (  .clk            (clk),
         .arst_n         (arst_n),
         .n_valid        (n_valid),
         .n_sign         (n_sign),
         .n_frac         (n_frac),
         .n_exp          (n_exp),
         .n_special      (n_special),
         .n_is_special   (n_is_special),
         .n_ovf_possible (n_ovf_possible),
         .r_valid        (r_valid),
         .r_y            (r_y),
         .r_ovf          (r_ovf));

   fmul_result_buffer
      #( .BUF_DEPTH   (BUF_DEPTH),
         .OUT_CREDITS (OUT_CREDITS))
   u_result_buffer
      (  .clk        (clk),
         .arst_n     (arst_n),
         .r_valid    (r_valid),
         .r_y        (r_y),
         .r_ovf      (r_ovf),
         .out_credit (out_credit),
         .out_valid  (out_valid),
         .out_y      (out_y),
         .out_ovf    (out_ovf),
         .in_credit  (in_credit));

endmodule

`default_nettype wire

// File: fmul_result_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module fmul_result_buffer
   import fmul_pkg::*;
   #( parameter int BUF_DEPTH   = 4,
      parameter int OUT_CREDITS = 2)
   (  input  logic   clk,
      input  logic   arst_n,
      input  logic   r_valid,
      input  float_t r_y,
      input  logic   r_ovf,
      input  logic   out_credit,
      output logic   out_valid,
      output float_t out_y,
      output logic   out_ovf,
      output logic   in_credit);

   localparam int AW = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
   localparam int CW = $clog2(BUF_DEPTH + 1);

   // entry is {ovf, y}
   logic [32:0]         mem [BUF_DEPTH];
   logic [AW-1:0]       wr_ptr;
   logic [AW-1:0]       rd_ptr;
   logic [CW-1:0]       count;
   logic [CREDIT_W-1:0] credits;
   logic                wr_en;
   logic                rd_en;

   function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
      if (p == AW'(BUF_DEPTH - 1)) begin
         return '0;
      end
      return p + 1'b1;
   endfunction

   // upstream credits guarantee room, so every result is written
   assign wr_en = r_valid;

   // pop needs data and a downstream credit
   assign rd_en = (count != '0) && (credits != '0);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         credits <= CREDIT_W'(OUT_CREDITS);
      end else begin
         if (wr_en) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (rd_en) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         count   <= count + CW'(wr_en) - CW'(rd_en);
         credits <= credits + CREDIT_W'(out_credit) - CREDIT_W'(rd_en);
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= {r_ovf, r_y};
      end
   end

   // head goes out directly, the popped slot is handed back upstream
   assign out_valid = rd_en;
   assign out_y     = mem[rd_ptr][31:0];
   assign out_ovf   = mem[rd_ptr][32];
   assign in_credit = rd_en;

endmodule

`default_nettype wire

// File: fmul_round_pack.sv
`timescale 1ns/10ps
`default_nettype none

module fmul_round_pack
   import fmul_pkg::*;
   (  input  logic   clk,
      input  logic   arst_n,
      input  logic   n_valid,
      input  logic   n_sign,
      input  prod_t  n_frac,
      input  wexp_t  n_exp,
      input  float_t n_special,
      input  logic   n_is_special,
      input  logic   n_ovf_possible,
      output logic   r_valid,
      output float_t r_y,
      output logic   r_ovf);

   wexp_t       exp_inc;
   wexp_t       sub_shift;
   exp_t        exp_r;
   exp_t        exp_ri;
   exp_t        exp_y;
   frac_t       frac_y;
   logic [70:0] frac_ext;
   logic [70:0] frac_sh;
   logic [24:0] frac_rnd;
   logic        ovf;
   float_t      y_next;

   // clamp working exponent into 0..255
   function automatic exp_t sat_exp(input wexp_t e);
      if (e[9]) begin
         return '0;
      end else if (e[8]) begin
         return EXP_MAX;
      end
      return e[7:0];
   endfunction

   assign exp_inc   = n_exp + wexp_t'(1);
   assign sub_shift = wexp_t'(1) - n_exp;
   assign exp_r     = sat_exp(n_exp);
   assign exp_ri    = sat_exp(exp_inc);

   // bits 70:47 keep the mantissa, bit 46 is the guard
   assign frac_ext = {n_frac, 23'd0};

   // denormalize on underflow
   always_comb begin
      if (n_exp[9]) begin
         frac_sh = frac_ext >> sub_shift[7:0];
      end else if (n_exp == '0) begin
         frac_sh = frac_ext >> 1;
      end else begin
         frac_sh = frac_ext;
      end
   end

   // round up whenever the guard bit is set
   assign frac_rnd = {1'b0, frac_sh[70:47]} + {24'd0, frac_sh[46]};

   always_comb begin
      if (frac_rnd[24]) begin
         // carry out of the mantissa, round again
         exp_y  = exp_ri;
         frac_y = '0;
      end else if (frac_rnd[23] && (exp_r == '0)) begin
         // subnormal rounded up to the smallest normal
         exp_y  = 8'd1;
         frac_y = frac_rnd[22:0];
      end else begin
         exp_y  = (frac_rnd[23:0] == '0) ? '0 : exp_r;
         frac_y = frac_rnd[22:0];
      end
   end

   assign ovf = n_ovf_possible && (exp_y == EXP_MAX);

   always_comb begin
      if (n_is_special) begin
         y_next = n_special;
      end else if (ovf) begin
         y_next = {n_sign, EXP_MAX, 23'd0};
      end else begin
         y_next = {n_sign, exp_y, frac_y};
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         r_valid <= 1'b0;
      end else begin
         r_valid <= n_valid;
      end
   end

   always_ff @(posedge clk) begin
      r_y   <= y_next;
      r_ovf <= ovf;
   end

endmodule

`default_nettype wire

// File: fmul_normalize.sv
`timescale 1ns/10ps
`default_nettype none

module fmul_normalize
   import fmul_pkg::*;
   (  input  logic   clk,
      input  logic   arst_n,
      input  logic   u_valid,
      input  logic   u_sign,
      input  mant_t  u_mant_a,
      input  mant_t  u_mant_b,
      input  wexp_t  u_exp_sum,
      input  float_t u_special,
      input  logic   u_is_special,
      input  logic   u_ovf_possible,
      output logic   n_valid,
      output logic   n_sign,
      output prod_t  n_frac,
      output wexp_t  n_exp,
      output float_t n_special,
      output logic   n_is_special,
      output logic   n_ovf_possible);

   prod_t  prod;
   prod_t  norm;
   shamt_t lead;
   wexp_t  exp_norm;

   // 24x24 unsigned product, format 2.46
   assign prod = prod_t'(u_mant_a) * prod_t'(u_mant_b);

   // leading-one search, highest set bit wins
   // a zero product gives 48
   always_comb begin
      lead = shamt_t'(48);
      for (int i = 0; i < 48; i++) begin
         if (prod[i]) begin
            lead = shamt_t'(47 - i);
         end
      end
   end

   // bring the leading one up to bit 47
   assign norm = prod << lead;

   // shift 0 means the product was already >= 2, hence the +1 in the bias
   assign exp_norm = u_exp_sum - wexp_t'({4'b0000, lead});

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         n_valid <= 1'b0;
      end else begin
         n_valid <= u_valid;
      end
   end

   always_ff @(posedge clk) begin
      n_sign         <= u_sign;
      n_frac         <= norm;
      n_exp          <= exp_norm;
      n_special      <= u_special;
      n_is_special   <= u_is_special;
      n_ovf_possible <= u_ovf_possible;
   end

endmodule

`default_nettype wire

// File: fmul_unpack.sv
`timescale 1ns/10ps
`default_nettype none

module fmul_unpack
   import fmul_pkg::*;
   (  input  logic   clk,
      input  logic   arst_n,
      input  logic   in_valid,
      input  float_t in_a,
      input  float_t in_b,
      output logic   u_valid,
      output logic   u_sign,
      output mant_t  u_mant_a,
      output mant_t  u_mant_b,
      output wexp_t  u_exp_sum,
      output float_t u_special,
      output logic   u_is_special,
      output logic   u_ovf_possible);

   logic   s_a;
   logic   s_b;
   exp_t   e_a;
   exp_t   e_b;
   frac_t  m_a;
   frac_t  m_b;
   exp_t   e_a_adj;
   exp_t   e_b_adj;
   mant_t  mant_a;
   mant_t  mant_b;
   logic   nan_a;
   logic   nan_b;
   logic   inf_a;
   logic   inf_b;
   logic   zero_a;
   logic   zero_b;
   wexp_t  exp_sum;
   float_t special;
   logic   is_special;

   assign s_a = in_a[31];
   assign e_a = in_a[30:23];
   assign m_a = in_a[22:0];
   assign s_b = in_b[31];
   assign e_b = in_b[30:23];
   assign m_b = in_b[22:0];

   // subnormal: no hidden bit, exponent taken as 1
   assign mant_a  = (e_a == '0) ? {1'b0, m_a} : {1'b1, m_a};
   assign mant_b  = (e_b == '0) ? {1'b0, m_b} : {1'b1, m_b};
   assign e_a_adj = (e_a == '0) ? 8'd1 : e_a;
   assign e_b_adj = (e_b == '0) ? 8'd1 : e_b;

   assign exp_sum = wexp_t'({2'b00, e_a_adj}) + wexp_t'({2'b00, e_b_adj})
                    - wexp_t'(EXP_BIAS_ADJ);

   assign nan_a  = (e_a == EXP_MAX) && (m_a != '0);
   assign nan_b  = (e_b == EXP_MAX) && (m_b != '0);
   assign inf_a  = (e_a == EXP_MAX) && (m_a == '0);
   assign inf_b  = (e_b == EXP_MAX) && (m_b == '0);
   assign zero_a = (e_a == '0) && (m_a == '0);
   assign zero_b = (e_b == '0) && (m_b == '0);

   // b's nan wins over a's, quiet bit always forced
   always_comb begin
      is_special = 1'b1;
      special    = {s_a ^ s_b, EXP_MAX, 23'd0};
      if (nan_b) begin
         special = {s_b, EXP_MAX, 1'b1, m_b[21:0]};
      end else if (nan_a) begin
         special = {s_a, EXP_MAX, 1'b1, m_a[21:0]};
      end else if (inf_a && zero_b) begin
         special = {1'b1, EXP_MAX, 1'b1, m_a[21:0]};
      end else if (inf_b && zero_a) begin
         special = {1'b1, EXP_MAX, 1'b1, m_b[21:0]};
      end else if (!(inf_a || inf_b)) begin
         is_special = 1'b0;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         u_valid <= 1'b0;
      end else begin
         u_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      u_sign         <= s_a ^ s_b;
      u_mant_a       <= mant_a;
      u_mant_b       <= mant_b;
      u_exp_sum      <= exp_sum;
      u_special      <= special;
      u_is_special   <= is_special;
      u_ovf_possible <= (e_a != EXP_MAX) && (e_b != EXP_MAX);
   end

endmodule

`default_nettype wire

// File: fmul_pkg.sv
package fmul_pkg;

   // ieee single word and its fields
   typedef logic [31:0] float_t;
   typedef logic [7:0]  exp_t;
   typedef logic [22:0] frac_t;

   // mantissa with hidden bit, and the raw product
   typedef logic [23:0] mant_t;
   typedef logic [47:0] prod_t;

   // working exponent, signed so underflow shows as negative
   typedef logic signed [9:0] wexp_t;

   // leading-one shift count, 0..48
   typedef logic [5:0] shamt_t;

   // all-ones exponent marks inf and nan
   localparam exp_t EXP_MAX = 8'd255;

   // product exponent is ea + eb - 127, plus one for the 2.46 product format
   localparam int EXP_BIAS_ADJ = 126;

   // downstream credit counter width
   localparam int CREDIT_W = 4;

endpackage
